// File: include/lab_defines.svh
`ifndef LAB_DEFINES_SVH
`define LAB_DEFINES_SVH

// shift register and history sizes
`define LAB_VALUE_W     8
`define LAB_HIST_DEPTH  4

// wide enough to hold LAB_HIST_DEPTH itself
`define LAB_CNT_W       3

// switch bit positions on the board
`define LAB_SW_STEP     0
`define LAB_SW_LOAD     1

// seed field sits in the upper byte of sw
`define LAB_SW_SEED_LO  8
`define LAB_SW_SEED_HI  15

// feedback taps of the 8-bit register
`define LAB_TAP_A       4
`define LAB_TAP_B       3
`define LAB_TAP_C       2
`define LAB_TAP_D       0

`endif

// File: source/lab_pkg.sv
package lab_pkg;

    `include "lab_defines.svh"

    // one produced value, seeded marks a load instead of a step
    typedef struct packed {
        logic [`LAB_VALUE_W-1:0] value;
        logic                    seeded;
    } sample_t;

    // entry 0 is the newest
    typedef struct packed {
        logic [`LAB_HIST_DEPTH-1:0][`LAB_VALUE_W-1:0] entry;
        logic [`LAB_CNT_W-1:0]                        count;
    } history_t;

    // active low, all segments and the point off
    localparam logic [7:0] SEG_BLANK = 8'hff;

    // bit order {dp, g, f, e, d, c, b, a}, active low
    function automatic logic [7:0] seg_hex(input logic [3:0] digit);
        logic [7:0] code;
        case (digit)
            4'h0: code = 8'hc0;
            4'h1: code = 8'hf9;
            4'h2: code = 8'ha4;
            4'h3: code = 8'hb0;
            4'h4: code = 8'h99;
            4'h5: code = 8'h92;
            4'h6: code = 8'h82;
            4'h7: code = 8'hf8;
            4'h8: code = 8'h80;
            4'h9: code = 8'h90;
            4'ha: code = 8'h88;
            4'hb: code = 8'h83;
            4'hc: code = 8'hc6;
            4'hd: code = 8'ha1;
            4'he: code = 8'h86;
            default: code = 8'h8e;
        endcase
        return code;
    endfunction

endpackage

// File: source/lfsr_gen.sv
`timescale 1ns/10ps

`include "lab_defines.svh"

module lfsr_gen
    import lab_pkg::*;
(
    input  logic                    btn,
    input  logic                    rst,
    input  logic                    step,
    input  logic                    load,
    input  logic [`LAB_VALUE_W-1:0] seed,
    output sample_t                 sample,
    output logic                    sample_valid
);

    logic [`LAB_VALUE_W-1:0] lfsr_q;
    logic [`LAB_VALUE_W-1:0] lfsr_step;
    logic                    feedback;
    logic                    seeded_q;
    logic                    valid_q;

    assign feedback = lfsr_q[`LAB_TAP_A] ^ lfsr_q[`LAB_TAP_B] ^
                      lfsr_q[`LAB_TAP_C] ^ lfsr_q[`LAB_TAP_D];

    // an all-zero register would never leave zero
    always_comb begin
        if (|lfsr_q) begin
            lfsr_step = {feedback, lfsr_q[`LAB_VALUE_W-1:1]};
        end else begin
            lfsr_step = `LAB_VALUE_W'(1);
        end
    end

    // load wins over step
    always_ff @(posedge btn) begin
        if (rst) begin
            lfsr_q   <= '0;
            seeded_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (load) begin
                lfsr_q   <= seed;
                seeded_q <= 1'b1;
                valid_q  <= 1'b1;
            end else if (step) begin
                lfsr_q   <= lfsr_step;
                seeded_q <= 1'b0;
                valid_q  <= 1'b1;
            end
        end
    end

    assign sample.value  = lfsr_q;
    assign sample.seeded = seeded_q;
    assign sample_valid  = valid_q;

endmodule

// File: source/history_buf.sv
`timescale 1ns/10ps

`include "lab_defines.svh"

module history_buf
    import lab_pkg::*;
(
    input  logic     btn,
    input  logic     rst,
    input  sample_t  sample,
    input  logic     sample_valid,
    output history_t hist
);

    localparam logic [`LAB_CNT_W-1:0] FULL_CNT = `LAB_CNT_W'(`LAB_HIST_DEPTH);

    logic [`LAB_HIST_DEPTH-1:0][`LAB_VALUE_W-1:0] entry_q;
    logic [`LAB_HIST_DEPTH-1:0][`LAB_VALUE_W-1:0] entry_shifted;
    logic [`LAB_CNT_W-1:0]                        count_q;
    logic [`LAB_CNT_W-1:0]                        count_next;
    logic                                         full;

    // newest goes in at entry 0, the oldest falls off the top
    always_comb begin
        entry_shifted[0] = sample.value;
        for (int i = 1; i < `LAB_HIST_DEPTH; i++) begin
            entry_shifted[i] = entry_q[i-1];
        end
    end

    assign full = (count_q == FULL_CNT);

    // count saturates once every slot holds a value
    always_comb begin
        if (full) begin
            count_next = count_q;
        end else begin
            count_next = count_q + `LAB_CNT_W'(1);
        end
    end

    always_ff @(posedge btn) begin
        if (rst) begin
            entry_q <= '0;
        end else if (sample_valid) begin
            entry_q <= entry_shifted;
        end
    end

    always_ff @(posedge btn) begin
        if (rst) begin
            count_q <= '0;
        end else if (sample_valid) begin
            count_q <= count_next;
        end
    end

    // seeded flag is not kept, a load is history too
    assign hist.entry = entry_q;
    assign hist.count = count_q;

endmodule

// File: source/hex_display.sv
`timescale 1ns/10ps

`include "lab_defines.svh"

module hex_display
    import lab_pkg::*;
(
    input  history_t    hist,
    output logic [7:0]  seg [2*`LAB_HIST_DEPTH],
    output logic [15:0] ledr
);

    logic [`LAB_HIST_DEPTH-1:0] filled;
    logic [`LAB_HIST_DEPTH-1:0] parity;
    logic                       any_set;

    // pair k is lit only once entry k has been written
    for (genvar k = 0; k < `LAB_HIST_DEPTH; k++) begin : g_pair
        logic [3:0] nib_lo;
        logic [3:0] nib_hi;

        assign nib_lo    = hist.entry[k][3:0];
        assign nib_hi    = hist.entry[k][7:4];
        assign filled[k] = (`LAB_CNT_W'(k) < hist.count);
        assign parity[k] = ^hist.entry[k];

        // low nibble on the even digit
        always_comb begin
            if (filled[k]) begin
                seg[2*k]   = seg_hex(nib_lo);
                seg[2*k+1] = seg_hex(nib_hi);
            end else begin
                seg[2*k]   = SEG_BLANK;
                seg[2*k+1] = SEG_BLANK;
            end
        end
    end

    assign any_set = |hist.entry;

    // current value, fill count, per-entry parity, any non-zero
    always_comb begin
        ledr        = '0;
        ledr[7:0]   = hist.entry[0];
        ledr[10:8]  = hist.count;
        ledr[14:11] = parity;
        ledr[15]    = any_set;
    end

endmodule

// File: source/lab_top.sv
`timescale 1ns/10ps

`include "lab_defines.svh"

module lab_top
    import lab_pkg::*;
(
    input  logic        btn,
    input  logic        rst,
    input  logic [15:0] sw,
    output logic [7:0]  seg0,
    output logic [7:0]  seg1,
    output logic [7:0]  seg2,
    output logic [7:0]  seg3,
    output logic [7:0]  seg4,
    output logic [7:0]  seg5,
    output logic [7:0]  seg6,
    output logic [7:0]  seg7,
    output logic [15:0] ledr
);

    logic                    step;
    logic                    load;
    logic [`LAB_VALUE_W-1:0] seed;
    sample_t                 sample;
    logic                    sample_valid;
    history_t                hist;
    logic [7:0]              seg [2*`LAB_HIST_DEPTH];

    // switch fields
    assign step = sw[`LAB_SW_STEP];
    assign load = sw[`LAB_SW_LOAD];
    assign seed = sw[`LAB_SW_SEED_HI:`LAB_SW_SEED_LO];

    lfsr_gen lfsr_gen_i (
        .btn          (btn),
        .rst          (rst),
        .step         (step),
        .load         (load),
        .seed         (seed),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    history_buf history_buf_i (
        .btn          (btn),
        .rst          (rst),
        .sample       (sample),
        .sample_valid (sample_valid),
        .hist         (hist)
    );

    hex_display hex_display_i (
        .hist (hist),
        .seg  (seg),
        .ledr (ledr)
    );

    // board digits
    assign seg0 = seg[0];
    assign seg1 = seg[1];
    assign seg2 = seg[2];
    assign seg3 = seg[3];
    assign seg4 = seg[4];
    assign seg5 = seg[5];
    assign seg6 = seg[6];
    assign seg7 = seg[7];

endmodule

// File: test/lab_asserts.sv
`timescale 1ns/10ps

`include "lab_defines.svh"

module lab_asserts
    import lab_pkg::*;
(
    input logic        btn,
    input logic        rst,
    input logic [15:0] sw,
    input sample_t     sample,
    input logic        sample_valid,
    input history_t    hist,
    input logic [7:0]  seg0
);

    localparam logic [`LAB_CNT_W-1:0] FULL_CNT = `LAB_CNT_W'(`LAB_HIST_DEPTH);

    int assert_errors = 0;

    // one pulse per step or load request
    a_pulse_on_request: assert property (@(posedge btn) disable iff (rst)
        (sw[`LAB_SW_STEP] || sw[`LAB_SW_LOAD]) |=> sample_valid)
    else begin
        $error("sample_valid missing after a step or load request");
        assert_errors++;
    end

    a_no_pulse_idle: assert property (@(posedge btn) disable iff (rst)
        !(sw[`LAB_SW_STEP] || sw[`LAB_SW_LOAD]) |=> !sample_valid)
    else begin
        $error("sample_valid pulsed without a request");
        assert_errors++;
    end

    // load takes the seed field, even with step on
    a_load_seed: assert property (@(posedge btn) disable iff (rst)
        sw[`LAB_SW_LOAD] |=>
            (sample.seeded && sample.value == $past(sw[`LAB_SW_SEED_HI:`LAB_SW_SEED_LO])))
    else begin
        $error("register did not take the seed on a load");
        assert_errors++;
    end

    // a plain step leaves the seeded flag clear
    a_step_unseeded: assert property (@(posedge btn) disable iff (rst)
        (sw[`LAB_SW_STEP] && !sw[`LAB_SW_LOAD]) |=> !sample.seeded)
    else begin
        $error("seeded flag set on a step without a load");
        assert_errors++;
    end

    a_hist_push: assert property (@(posedge btn) disable iff (rst)
        sample_valid |=> hist.entry[0] == $past(sample.value))
    else begin
        $error("history entry 0 did not take the pulsed sample");
        assert_errors++;
    end

    a_count_bound: assert property (@(posedge btn) disable iff (rst)
        hist.count <= FULL_CNT)
    else begin
        $error("history fill count exceeded the depth");
        assert_errors++;
    end

    a_blank_empty: assert property (@(posedge btn) disable iff (rst)
        hist.count == '0 |-> seg0 == SEG_BLANK)
    else begin
        $error("seg0 lit while the history is empty");
        assert_errors++;
    end

endmodule

bind lab_top lab_asserts lab_asserts_i (
    .btn          (btn),
    .rst          (rst),
    .sw           (sw),
    .sample       (sample),
    .sample_valid (sample_valid),
    .hist         (hist),
    .seg0         (seg0)
);

// File: test/lab_tb.sv
`timescale 1ns/10ps

`include "lab_defines.svh"

module lab_tb;

    localparam int DEPTH = `LAB_HIST_DEPTH;
    localparam logic [`LAB_CNT_W-1:0] DEPTH_CNT = `LAB_CNT_W'(`LAB_HIST_DEPTH);

    // standard active-low hex glyphs, bit order {dp, g, f, e, d, c, b, a}
    localparam logic [7:0] GLYPHS [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    logic        btn = 1'b0;
    logic        rst;
    logic [15:0] sw;
    logic [7:0]  seg0;
    logic [7:0]  seg1;
    logic [7:0]  seg2;
    logic [7:0]  seg3;
    logic [7:0]  seg4;
    logic [7:0]  seg5;
    logic [7:0]  seg6;
    logic [7:0]  seg7;
    logic [15:0] ledr;
    logic [7:0]  seg_obs [2*DEPTH];

    // reference model of register, pulse and history
    logic [`LAB_VALUE_W-1:0] lfsr_m;
    logic                    valid_m;
    logic [`LAB_VALUE_W-1:0] hist_m [DEPTH];
    logic [`LAB_CNT_W-1:0]   count_m;

    int          mismatch_count = 0;
    logic        timed_out;
    logic [31:0] rnd;

    lab_top dut_i (
        .btn  (btn),
        .rst  (rst),
        .sw   (sw),
        .seg0 (seg0),
        .seg1 (seg1),
        .seg2 (seg2),
        .seg3 (seg3),
        .seg4 (seg4),
        .seg5 (seg5),
        .seg6 (seg6),
        .seg7 (seg7),
        .ledr (ledr)
    );

    assign seg_obs[0] = seg0;
    assign seg_obs[1] = seg1;
    assign seg_obs[2] = seg2;
    assign seg_obs[3] = seg3;
    assign seg_obs[4] = seg4;
    assign seg_obs[5] = seg5;
    assign seg_obs[6] = seg6;
    assign seg_obs[7] = seg7;

    always #5 btn = ~btn;

    function automatic logic [7:0] lfsr_next(input logic [7:0] cur);
        logic [7:0] nxt;
        if (cur == 8'h00) begin
            nxt = 8'h01;
        end else begin
            nxt = {cur[4] ^ cur[3] ^ cur[2] ^ cur[0], cur[7:1]};
        end
        return nxt;
    endfunction

    always @(posedge btn) begin
        if (rst) begin
            lfsr_m  <= '0;
            valid_m <= 1'b0;
            count_m <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                hist_m[i] <= '0;
            end
        end else begin
            valid_m <= 1'b0;
            if (sw[`LAB_SW_LOAD]) begin
                lfsr_m  <= sw[`LAB_SW_SEED_HI:`LAB_SW_SEED_LO];
                valid_m <= 1'b1;
            end else if (sw[`LAB_SW_STEP]) begin
                lfsr_m  <= lfsr_next(lfsr_m);
                valid_m <= 1'b1;
            end
            // history lags the register by one edge
            if (valid_m) begin
                hist_m[0] <= lfsr_m;
                for (int i = 1; i < DEPTH; i++) begin
                    hist_m[i] <= hist_m[i-1];
                end
                if (count_m != DEPTH_CNT) begin
                    count_m <= count_m + `LAB_CNT_W'(1);
                end
            end
        end
    end

    function automatic logic [15:0] expected_leds();
        logic [15:0] leds;
        logic        any_set;
        leds       = 16'h0000;
        any_set    = 1'b0;
        leds[7:0]  = hist_m[0];
        leds[10:8] = count_m;
        for (int k = 0; k < DEPTH; k++) begin
            leds[11+k] = ^hist_m[k];
            any_set    = any_set | (hist_m[k] != 8'h00);
        end
        leds[15] = any_set;
        return leds;
    endfunction

    function automatic logic [7:0] expected_seg(input int idx);
        int         k;
        logic [7:0] value;
        logic [7:0] code;
        k     = idx / 2;
        value = hist_m[k];
        if (k >= int'(count_m)) begin
            code = 8'hff;
        end else if (idx % 2 == 0) begin
            code = GLYPHS[value[3:0]];
        end else begin
            code = GLYPHS[value[7:4]];
        end
        return code;
    endfunction

    task automatic compare_outputs();
        logic [15:0] exp_led;
        logic [7:0]  exp_seg;
        exp_led = expected_leds();
        assert (ledr == exp_led) else begin
            $display("Mismatch at %0t: ledr is %04h, expected %04h", $time, ledr, exp_led);
            mismatch_count++;
        end
        for (int i = 0; i < 2*DEPTH; i++) begin
            exp_seg = expected_seg(i);
            assert (seg_obs[i] == exp_seg) else begin
                $display("Mismatch at %0t: seg%0d is %02h, expected %02h",
                         $time, i, seg_obs[i], exp_seg);
                mismatch_count++;
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge btn) begin
        compare_outputs();
    end

    function automatic logic [15:0] switch_word(input logic step, input logic load,
                                                input logic [7:0] seed);
        return {seed, 6'b000000, load, step};
    endfunction

    task automatic drive_sw(input logic [15:0] value);
        @(posedge btn);
        #1;
        sw = value;
    endtask

    task automatic wait_for_led(input logic [7:0] value, input int limit);
        logic found;
        found = 1'b0;
        for (int c = 0; c < limit && !found; c++) begin
            @(negedge btn);
            found = (ledr[7:0] == value);
        end
        if (!found) begin
            $display("Timeout: ledr[7:0] never showed %02h within %0d cycles", value, limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_random(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            rnd = $urandom();
            drive_sw(switch_word(rnd[16], rnd[23:20] == 4'h0, rnd[15:8]));
        end
        drive_sw(16'h0000);
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = dut_i.lab_asserts_i.assert_errors;
        $display("Errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 mismatch_count, assert_fails, timed_out);
        if (mismatch_count == 0 && assert_fails == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        rst       = 1'b1;
        sw        = 16'h0000;
        timed_out = 1'b0;
        rnd       = $urandom(32'h7047);
        repeat (5) @(posedge btn);
        #1;
        rst = 1'b0;
        // load and step together, load wins
        drive_sw(switch_word(1'b1, 1'b1, 8'ha5));
        drive_sw(16'h0000);
        wait_for_led(8'ha5, 8);
        // zero seed, then one step out of the all-zero state
        if (!timed_out) begin
            drive_sw(switch_word(1'b0, 1'b1, 8'h00));
            drive_sw(switch_word(1'b1, 1'b0, 8'h00));
            drive_sw(16'h0000);
            wait_for_led(8'h01, 8);
        end
        if (!timed_out) begin
            run_random(80);
            repeat (4) @(negedge btn);
        end
        @(posedge btn);
        finish_run();
    end

endmodule

// File: compile.f
+incdir+include
source/lab_pkg.sv
source/lfsr_gen.sv
source/history_buf.sv
source/hex_display.sv
source/lab_top.sv
test/lab_asserts.sv
test/lab_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := lab_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
